//--- tests/golden_resolve.txt
# name stall valid kind pc taken target prediction ghr expected_redirect
# kind 0 cond, 1 jal, 2 jalr; stall count decimal, other fields hex
reset_run      0 0 0 00000000 0 00000000 0 00 00000000
stall_hold     6 0 0 00000000 0 00000000 0 00 00000000
cond_taken     0 1 0 00000040 1 00000100 0 00 00000100
jal_train1     0 1 1 00000200 1 00000300 0 07 00000300
jal_train2     2 1 1 00000200 1 00000300 0 07 00000300
jalr_to_jal    0 1 2 00000120 1 000001f8 0 07 000001f8
jalr_predicted 0 1 2 00000124 1 000002a0 1 00 000002a0
cond_not_taken 0 1 0 00000080 0 00000500 1 07 00000084
cond_correct   3 1 0 00000090 0 00000600 0 0e 00000000
stall_late     4 0 0 00000000 0 00000000 0 00 00000000

//--- files.f
src/bp_pkg.sv
src/pred_table.sv
src/pred_lookup.sv
src/pc_gen.sv
src/resolve_stage.sv
src/fetch_frontend.sv
tests/frontend_chk.sv
tests/fetch_checker.sv
tests/tb_top.sv

//--- Makefile
TOP := tb_top

all: run

obj_dir/V$(TOP): files.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- tests/tb_top.sv
`timescale 1ns/1ns

module tb_top
    import bp_pkg::*;
();

    localparam int CLK_PERIOD = 10;

    logic         clk;
    logic         rst_n;
    logic         stall;
    resolve_t     resolve;
    fetch_t       fetch;

    logic         test_end;
    logic [127:0] test_name;
    logic [31:0]  exp_redirect;
    int           pass_cnt;
    int           fail_cnt;

    // Golden test lines, one entry per test
    logic [127:0] name_q[$];
    int           stall_q[$];
    resolve_t     res_q[$];
    logic [31:0]  exp_q[$];
    logic         loaded;
    int           seed;

    fetch_frontend fetch_frontend_i (
        .clk_i     (clk),
        .rst_ni    (rst_n),
        .stall_i   (stall),
        .resolve_i (resolve),
        .fetch_o   (fetch)
    );

    fetch_checker u_checker (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .stall_i        (stall),
        .resolve_i      (resolve),
        .fetch_i        (fetch),
        .test_end_i     (test_end),
        .test_name_i    (test_name),
        .exp_redirect_i (exp_redirect),
        .pass_cnt_o     (pass_cnt),
        .fail_cnt_o     (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_golden();
        int           fd;
        int           n;
        string        line;
        logic [127:0] name;
        int           stall_cnt;
        logic [31:0]  f_valid;
        logic [31:0]  f_kind;
        logic [31:0]  f_pc;
        logic [31:0]  f_taken;
        logic [31:0]  f_target;
        logic [31:0]  f_pred;
        logic [31:0]  f_ghr;
        logic [31:0]  f_exp;
        resolve_t     r;
        fd = $fopen("tests/golden_resolve.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/golden_resolve.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Skip blank and comment lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h", name, stall_cnt,
                                f_valid, f_kind, f_pc, f_taken, f_target, f_pred, f_ghr, f_exp);
                    if (n == 10) begin
                        r            = '0;
                        r.valid      = f_valid[0];
                        r.kind       = br_kind_e'(f_kind[1:0]);
                        r.pc         = f_pc;
                        r.taken      = f_taken[0];
                        r.target     = f_target;
                        r.prediction = f_pred[0];
                        r.ghr        = f_ghr[HISTORY_WIDTH-1:0];
                        name_q.push_back(name);
                        stall_q.push_back(stall_cnt);
                        res_q.push_back(r);
                        exp_q.push_back(f_exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Stall phase, one resolved branch, then the redirect window
    task automatic run_test(int idx);
        int gap;
        test_name    = name_q[idx];
        exp_redirect = exp_q[idx];
        if (stall_q[idx] > 0) begin
            stall = 1'b1;
            repeat (stall_q[idx]) @(posedge clk);
            #1;
            stall = 1'b0;
        end
        resolve = res_q[idx];
        @(posedge clk);
        #1;
        resolve = '0;
        repeat (3) @(posedge clk);
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clk);
        #1;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    task automatic finish_run();
        repeat (2) @(posedge clk);
        $display("Tests: %0d run, %0d passed, %0d failed", name_q.size(), pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == name_q.size()) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin
        rst_n        = 1'b0;
        stall        = 1'b0;
        resolve      = '0;
        test_end     = 1'b0;
        test_name    = '0;
        exp_redirect = '0;
        seed         = 84929;
        loaded       = 1'b0;
        load_golden();
        if (name_q.size() == 0) begin
            $display("No test lines could be read from tests/golden_resolve.txt");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (16) @(posedge clk);
            #1;
            rst_n = 1'b1;
            foreach (name_q[i]) begin
                run_test(i);
            end
            finish_run();
        end
    end

    // Each test fits well inside 40 cycles, plus reset and drain
    initial begin
        wait (loaded);
        repeat (name_q.size() * 40 + 200) @(posedge clk);
        $display("Timeout: the tests did not finish within the cycle budget");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tests/fetch_checker.sv
`timescale 1ns/1ns

module fetch_checker
    import bp_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         stall_i,
    input  resolve_t     resolve_i,
    input  fetch_t       fetch_i,
    input  logic         test_end_i,
    input  logic [127:0] test_name_i,
    input  logic [31:0]  exp_redirect_i,
    output int           pass_cnt_o,
    output int           fail_cnt_o
);

    localparam int BTB_DEPTH = 1 << INDEX_WIDTH;
    localparam int PHT_DEPTH = 1 << HISTORY_WIDTH;

    // Model state
    logic                     btb_valid  [BTB_DEPTH];
    logic [TAG_WIDTH-1:0]     btb_tag    [BTB_DEPTH];
    logic [XLEN-1:0]          btb_target [BTB_DEPTH];
    logic [1:0]               pht        [PHT_DEPTH];
    logic [HISTORY_WIDTH-1:0] ghr;
    logic [XLEN-1:0]          pc;
    fetch_t                   fetch_exp;
    resolve_t                 res;
    int                       redirect_age;

    logic [XLEN-1:0]          seen_redirect;
    int                       test_errs;

    task automatic reset_model();
        for (int i = 0; i < BTB_DEPTH; i++) begin
            btb_valid[i]  = 1'b0;
            btb_tag[i]    = '0;
            btb_target[i] = '0;
        end
        // Weakly not taken
        for (int i = 0; i < PHT_DEPTH; i++) begin
            pht[i] = 2'd1;
        end
        ghr          = '0;
        pc           = '0;
        fetch_exp    = '0;
        res          = '0;
        redirect_age = 0;
    endtask

    task automatic step_model();
        logic                     mispredict;
        logic [XLEN-1:0]          recovery;
        logic [INDEX_WIDTH-1:0]   bidx;
        logic [HISTORY_WIDTH-1:0] pidx;
        logic                     hit;
        logic                     pred_taken;
        logic                     trains;
        mispredict = 1'b0;
        recovery   = res.taken ? res.target : res.pc + 32'd4;
        trains     = res.valid && (res.kind == BR_COND || res.kind == BR_JAL);
        if (res.valid) begin
            mispredict = (res.kind == BR_JALR) || (res.prediction != res.taken);
        end
        // Age 2 marks the edge where the recovery pc enters fetch
        if (redirect_age == 2) begin
            redirect_age = 0;
        end else if (redirect_age == 1) begin
            redirect_age = 2;
        end
        bidx       = pc[INDEX_WIDTH+1:2];
        pidx       = pc[HISTORY_WIDTH+1:2] ^ ghr;
        hit        = btb_valid[bidx] && (btb_tag[bidx] == pc[XLEN-1:INDEX_WIDTH+2]);
        pred_taken = hit && (pht[pidx] >= 2'd2);
        if (mispredict) begin
            fetch_exp    = '0;
            pc           = recovery;
            redirect_age = 1;
        end else if (!stall_i) begin
            fetch_exp.valid      = 1'b1;
            fetch_exp.pc         = pc;
            fetch_exp.prediction = pred_taken;
            fetch_exp.btb_hit    = hit;
            fetch_exp.ghr        = ghr;
            pc = pred_taken ? btb_target[bidx] : pc + 32'd4;
        end
        if (trains) begin
            pidx = res.pc[HISTORY_WIDTH+1:2] ^ res.ghr;
            if (res.taken) begin
                if (pht[pidx] != 2'd3) begin
                    pht[pidx] = pht[pidx] + 2'd1;
                end
                bidx             = res.pc[INDEX_WIDTH+1:2];
                btb_valid[bidx]  = 1'b1;
                btb_tag[bidx]    = res.pc[XLEN-1:INDEX_WIDTH+2];
                btb_target[bidx] = res.target;
            end else if (pht[pidx] != 2'd0) begin
                pht[pidx] = pht[pidx] - 2'd1;
            end
            ghr = {ghr[HISTORY_WIDTH-2:0], res.taken};
        end
        res = resolve_i;
    endtask

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            reset_model();
        end else begin
            step_model();
        end
    end

    task automatic report_mismatch(string field, logic [31:0] exp, logic [31:0] act);
        $display("[FAIL] %0s fetch %0s expected %h actual %h", test_name_i, field, exp, act);
        test_errs++;
    endtask

    task automatic check_fetch();
        if (fetch_i.valid !== fetch_exp.valid) begin
            report_mismatch("valid", 32'(fetch_exp.valid), 32'(fetch_i.valid));
        end else if (fetch_exp.valid) begin
            if (fetch_i.pc !== fetch_exp.pc) begin
                report_mismatch("pc", fetch_exp.pc, fetch_i.pc);
            end
            if (fetch_i.prediction !== fetch_exp.prediction) begin
                report_mismatch("prediction", 32'(fetch_exp.prediction),
                                32'(fetch_i.prediction));
            end
            if (fetch_i.btb_hit !== fetch_exp.btb_hit) begin
                report_mismatch("btb_hit", 32'(fetch_exp.btb_hit), 32'(fetch_i.btb_hit));
            end
            if (fetch_i.ghr !== fetch_exp.ghr) begin
                report_mismatch("ghr", 32'(fetch_exp.ghr), 32'(fetch_i.ghr));
            end
        end
    endtask

    task automatic close_test();
        if (seen_redirect !== exp_redirect_i) begin
            $display("[FAIL] %0s redirect expected %h actual %h",
                     test_name_i, exp_redirect_i, seen_redirect);
            fail_cnt_o++;
        end else if (test_errs != 0) begin
            $display("[FAIL] %0s had %0d fetch mismatches", test_name_i, test_errs);
            fail_cnt_o++;
        end else begin
            $display("[PASS] %0s", test_name_i);
            pass_cnt_o++;
        end
        test_errs     = 0;
        seen_redirect = '0;
    endtask

    // Outputs settle between edges, so compare on the falling edge
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            pass_cnt_o    = 0;
            fail_cnt_o    = 0;
            test_errs     = 0;
            seen_redirect = '0;
        end else begin
            check_fetch();
            if (redirect_age == 2 && fetch_i.valid) begin
                seen_redirect = fetch_i.pc;
            end
            if (test_end_i) begin
                close_test();
            end
        end
    end

endmodule

//--- tests/frontend_chk.sv
`timescale 1ns/1ns

module frontend_chk
    import bp_pkg::*;
(
    input logic            clk_i,
    input logic            rst_ni,
    input logic            stall_i,
    input redirect_t       redirect_i,
    input logic [XLEN-1:0] pc_i,
    input fetch_t          fetch_i
);

    reset_clears_fetch: assert property (@(posedge clk_i) !rst_ni |-> !fetch_i.valid)
        else $error("fetch_o is valid while reset is held");

    // Redirect takes priority, so only a plain stall must hold
    stall_holds_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (stall_i && !redirect_i.valid) |=> $stable(fetch_i))
        else $error("fetch_o changed during a stall");

    redirect_flushes_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
        redirect_i.valid |=> !fetch_i.valid)
        else $error("fetch_o still valid after a redirect");

    pc_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pc_i[1:0] == 2'b00)
        else $error("PC is not word aligned");

endmodule

bind fetch_frontend frontend_chk u_frontend_chk (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .stall_i    (stall_i),
    .redirect_i (redirect),
    .pc_i       (pc),
    .fetch_i    (fetch_o)
);

//--- src/fetch_frontend.sv
`timescale 1ns/1ns

module fetch_frontend
    import bp_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     stall_i,
    input  resolve_t resolve_i,
    output fetch_t   fetch_o
);

    logic [XLEN-1:0]          pc;
    logic                     btb_hit;
    logic                     prediction;
    logic [XLEN-1:0]          target;
    logic [HISTORY_WIDTH-1:0] ghr;
    redirect_t                redirect;
    tbl_update_t              upd;

    pc_gen u_pc_gen (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .stall_i      (stall_i),
        .redirect_i   (redirect),
        .btb_hit_i    (btb_hit),
        .prediction_i (prediction),
        .target_i     (target),
        .ghr_i        (ghr),
        .pc_o         (pc),
        .fetch_o      (fetch_o)
    );

    pred_lookup u_pred_lookup (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pc_i         (pc),
        .upd_i        (upd),
        .btb_hit_o    (btb_hit),
        .prediction_o (prediction),
        .target_o     (target),
        .ghr_o        (ghr)
    );

    // Plays the memory-stage end of the branch path
    resolve_stage u_resolve_stage (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .resolve_i  (resolve_i),
        .redirect_o (redirect),
        .upd_o      (upd)
    );

endmodule

//--- src/resolve_stage.sv
`timescale 1ns/1ns

module resolve_stage
    import bp_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  resolve_t    resolve_i,
    output redirect_t   redirect_o,
    output tbl_update_t upd_o
);

    logic     res_valid_q;
    resolve_t res_data_q;
    logic     trainable;
    logic     mispredict;

    // Resolution pipeline register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= resolve_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        res_data_q <= resolve_i;
    end

    // Conditional branches and direct jumps go through the predictor
    assign trainable = (res_data_q.kind == BR_COND) || (res_data_q.kind == BR_JAL);

    // Indirect jumps are never predicted, so they always recover
    assign mispredict = res_valid_q &&
                        ((trainable && (res_data_q.prediction != res_data_q.taken)) ||
                         (res_data_q.kind == BR_JALR));

    always_comb begin
        redirect_o.valid = mispredict;
        if (res_data_q.taken) begin
            redirect_o.pc = res_data_q.target;
        end else begin
            redirect_o.pc = res_data_q.pc + 32'd4;
        end
    end

    // Training command to the lookup tables
    always_comb begin
        upd_o.valid  = res_valid_q && trainable;
        upd_o.pc     = res_data_q.pc;
        upd_o.kind   = res_data_q.kind;
        upd_o.taken  = res_data_q.taken;
        upd_o.target = res_data_q.target;
        upd_o.ghr    = res_data_q.ghr;
    end

endmodule

//--- src/pc_gen.sv
`timescale 1ns/1ns

module pc_gen
    import bp_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     stall_i,
    input  redirect_t                redirect_i,
    input  logic                     btb_hit_i,
    input  logic                     prediction_i,
    input  logic [XLEN-1:0]          target_i,
    input  logic [HISTORY_WIDTH-1:0] ghr_i,
    output logic [XLEN-1:0]          pc_o,
    output fetch_t                   fetch_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    fetch_t          fetch_q;

    // Recovery wins over stall, stall wins over prediction
    always_comb begin
        if (redirect_i.valid) begin
            pc_next = redirect_i.pc;
        end else if (stall_i) begin
            pc_next = pc_q;
        end else if (prediction_i) begin
            pc_next = target_i;
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    // Fetch register, flushed on redirect
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fetch_q <= '0;
        end else if (redirect_i.valid) begin
            fetch_q <= '0;
        end else if (!stall_i) begin
            fetch_q.valid      <= 1'b1;
            fetch_q.pc         <= pc_q;
            fetch_q.prediction <= prediction_i;
            fetch_q.btb_hit    <= btb_hit_i;
            fetch_q.ghr        <= ghr_i;
        end
    end

    assign pc_o    = pc_q;
    assign fetch_o = fetch_q;

endmodule

//--- src/pred_lookup.sv
`timescale 1ns/1ns

module pred_lookup
    import bp_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [XLEN-1:0]          pc_i,
    input  tbl_update_t              upd_i,
    output logic                     btb_hit_o,
    output logic                     prediction_o,
    output logic [XLEN-1:0]          target_o,
    output logic [HISTORY_WIDTH-1:0] ghr_o
);

    logic [HISTORY_WIDTH-1:0] ghr_q;

    logic [INDEX_WIDTH-1:0]   btb_rd_idx;
    logic [INDEX_WIDTH-1:0]   btb_wr_idx;
    logic [HISTORY_WIDTH-1:0] pht_rd_idx;
    logic [HISTORY_WIDTH-1:0] pht_wr_idx;

    btb_entry_t btb_rd;
    btb_entry_t btb_wr;
    pht_cnt_t   pht_rd;
    pht_cnt_t   pht_cur;
    pht_cnt_t   pht_wr;

    // Fetch side indexes, gshare hash on the counter table
    assign btb_rd_idx = pc_i[INDEX_WIDTH+1:2];
    assign pht_rd_idx = pc_i[HISTORY_WIDTH+1:2] ^ ghr_q;

    // Training side uses the history snapshot carried with the branch
    assign btb_wr_idx = upd_i.pc[INDEX_WIDTH+1:2];
    assign pht_wr_idx = upd_i.pc[HISTORY_WIDTH+1:2] ^ upd_i.ghr;

    assign btb_wr.valid  = 1'b1;
    assign btb_wr.tag    = upd_i.pc[XLEN-1:INDEX_WIDTH+2];
    assign btb_wr.target = upd_i.target;

    // Saturating counter step
    always_comb begin
        pht_wr = pht_cur;
        if (upd_i.taken && pht_cur != 2'b11) begin
            pht_wr = pht_cur + 2'b01;
        end else if (!upd_i.taken && pht_cur != 2'b00) begin
            pht_wr = pht_cur - 2'b01;
        end
    end

    pred_table #(
        .entry_t    (btb_entry_t),
        .DEPTH_LOG2 (INDEX_WIDTH),
        .RESET_VAL  ('0)
    ) u_btb (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_idx_i  (btb_rd_idx),
        .wr_en_i   (upd_i.valid && upd_i.taken),
        .wr_idx_i  (btb_wr_idx),
        .wr_data_i (btb_wr),
        .rd_data_o (btb_rd),
        .wr_cur_o  ()
    );

    pred_table #(
        .entry_t    (pht_cnt_t),
        .DEPTH_LOG2 (HISTORY_WIDTH),
        .RESET_VAL  (PHT_INIT)
    ) u_pht (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_idx_i  (pht_rd_idx),
        .wr_en_i   (upd_i.valid),
        .wr_idx_i  (pht_wr_idx),
        .wr_data_i (pht_wr),
        .rd_data_o (pht_rd),
        .wr_cur_o  (pht_cur)
    );

    // Global history, newest outcome in bit 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (upd_i.valid) begin
            ghr_q <= {ghr_q[HISTORY_WIDTH-2:0], upd_i.taken};
        end
    end

    assign btb_hit_o    = btb_rd.valid && (btb_rd.tag == pc_i[XLEN-1:INDEX_WIDTH+2]);
    assign prediction_o = btb_hit_o && pht_rd[1];
    assign target_o     = btb_rd.target;
    assign ghr_o        = ghr_q;

endmodule

//--- src/pred_table.sv
`timescale 1ns/1ns

module pred_table #(
    parameter type    entry_t    = logic [1:0],
    parameter int     DEPTH_LOG2 = 6,
    parameter entry_t RESET_VAL  = '0
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [DEPTH_LOG2-1:0] rd_idx_i,
    input  logic                  wr_en_i,
    input  logic [DEPTH_LOG2-1:0] wr_idx_i,
    input  entry_t                wr_data_i,
    output entry_t                rd_data_o,
    output entry_t                wr_cur_o
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    entry_t mem_q [DEPTH];

    // Every entry comes out of reset at the same value
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_data_i;
        end
    end

    // Lookup read
    assign rd_data_o = mem_q[rd_idx_i];

    // Current content at the write slot, for read-modify-write users
    assign wr_cur_o = mem_q[wr_idx_i];

endmodule

//--- src/bp_pkg.sv
package bp_pkg;

    // Address and table geometry
    localparam int XLEN          = 32;
    localparam int INDEX_WIDTH   = 6;
    localparam int HISTORY_WIDTH = 6;
    localparam int TAG_WIDTH     = XLEN - INDEX_WIDTH - 2;

    // Two-bit pattern counter, weakly not taken out of reset
    typedef logic [1:0] pht_cnt_t;
    localparam pht_cnt_t PHT_INIT = 2'b01;

    typedef enum logic [1:0] {
        BR_COND = 2'b00,
        BR_JAL  = 2'b01,
        BR_JALR = 2'b10
    } br_kind_e;

    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] tag;
        logic [XLEN-1:0]      target;
    } btb_entry_t;

    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          pc;
        logic                     prediction;
        logic                     btb_hit;
        logic [HISTORY_WIDTH-1:0] ghr;
    } fetch_t;

    typedef struct packed {
        logic                     valid;
        br_kind_e                 kind;
        logic [XLEN-1:0]          pc;
        logic                     taken;
        logic [XLEN-1:0]          target;
        logic                     prediction;
        logic [HISTORY_WIDTH-1:0] ghr;
    } resolve_t;

    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          pc;
        br_kind_e                 kind;
        logic                     taken;
        logic [XLEN-1:0]          target;
        logic [HISTORY_WIDTH-1:0] ghr;
    } tbl_update_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

endpackage
